// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module camera_tx_tb

sim:
	verilator --binary --timing --assert -f all.f --top-module camera_tx_tb \
		-Mdir obj_dir -o camera_tx_sim
	./obj_dir/camera_tx_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Checks failed" sim.log || \
		! grep -q "All checks passed" sim.log; then \
		echo "simulation did not pass"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
+incdir+logic
logic/csi_packet_pkg.sv
logic/camera_reg_pkg.sv
logic/color_bar_generator.sv
logic/raw10_packer.sv
logic/packet_sequencer.sv
logic/camera_config_regs.sv
logic/camera_tx_top.sv
testbench/camera_tx_properties.sv
testbench/camera_tx_tb.sv

// ==== logic/camera_config_regs.sv ====
// AXI4-Lite register block with enable control and frame counter
`timescale 1ns/100ps
`include "camera_tx_defs.svh"

module camera_config_regs (
    input  logic                      clock_camera_byte,
    input  logic                      reset_camera_byte_n,
    input  logic                      frame_done_i,
    output logic                      enable_o,
    input  logic [31:0]               awaddr_i,
    input  logic                      awvalid_i,
    output logic                      awready_o,
    input  logic [31:0]               wdata_i,
    input  logic [3:0]                wstrb_i,
    input  logic                      wvalid_i,
    output logic                      wready_o,
    output camera_reg_pkg::axi_resp_t bresp_o,
    output logic                      bvalid_o,
    input  logic                      bready_i,
    input  logic [31:0]               araddr_i,
    input  logic                      arvalid_i,
    output logic                      arready_o,
    output logic [31:0]               rdata_o,
    output camera_reg_pkg::axi_resp_t rresp_o,
    output logic                      rvalid_o,
    input  logic                      rready_i
);
    import camera_reg_pkg::*;

    logic        write_accept;
    logic        read_accept;
    logic        write_addr_ok;
    logic        read_addr_ok;
    reg_index_t  write_index;
    reg_index_t  read_index;
    logic [31:0] frame_count;

    // address and data must arrive together, one response outstanding
    assign write_accept = awvalid_i && wvalid_i && !bvalid_o;
    assign read_accept  = arvalid_i && !rvalid_o;
    assign awready_o    = write_accept;
    assign wready_o     = write_accept;
    assign arready_o    = read_accept;

    assign write_index   = reg_index_t'(awaddr_i[2]);
    assign read_index    = reg_index_t'(araddr_i[2]);
    assign write_addr_ok = (awaddr_i == `CAM_REG_CONTROL) || (awaddr_i == `CAM_REG_STATUS);
    assign read_addr_ok  = (araddr_i == `CAM_REG_CONTROL) || (araddr_i == `CAM_REG_STATUS);

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            enable_o    <= 1'b0;
            frame_count <= '0;
            bvalid_o    <= 1'b0;
            rvalid_o    <= 1'b0;
        end else begin
            if (frame_done_i) frame_count <= frame_count + 1'b1;
            if (write_accept) bvalid_o <= 1'b1;
            else if (bready_i) bvalid_o <= 1'b0;
            if (read_accept) rvalid_o <= 1'b1;
            else if (rready_i) rvalid_o <= 1'b0;
            if (write_accept && write_addr_ok && write_index == CONTROL && wstrb_i[0]) begin
                enable_o <= wdata_i[0];
            end
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        if (write_accept) begin
            bresp_o <= (write_addr_ok && write_index == CONTROL) ? OKAY : SLVERR; // status is read-only
        end
        if (read_accept) begin
            rresp_o <= read_addr_ok ? OKAY : SLVERR;
            if (!read_addr_ok) rdata_o <= '0;
            else rdata_o <= (read_index == STATUS) ? frame_count : {31'd0, enable_o};
        end
    end

endmodule

// ==== logic/camera_reg_pkg.sv ====
// register index and AXI response encodings for the configuration block
package camera_reg_pkg;

    // selected by address bit 2
    typedef enum logic {
        CONTROL = 1'b0,
        STATUS  = 1'b1
    } reg_index_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

// ==== logic/camera_tx_defs.svh ====
// image size, packet gap, color bar values and register addresses
`ifndef CAMERA_TX_DEFS_SVH
`define CAMERA_TX_DEFS_SVH

// image geometry in pixels and lines
`define CAM_IMAGE_X_SIZE 16
`define CAM_IMAGE_Y_SIZE 4

// idle cycles after each packet
`define CAM_LINE_GAP 4

// bar colors, red 29:20, green 19:10, blue 9:0
`define CAM_COLOR_BAR0 30'h000993fc
`define CAM_COLOR_BAR1 30'h3fcff000
`define CAM_COLOR_BAR2 30'h3fc003fc
`define CAM_COLOR_BAR3 30'h0cccc0cc

// AXI4-Lite byte addresses
`define CAM_REG_CONTROL 32'h0000_0000
`define CAM_REG_STATUS  32'h0000_0004

`endif

// ==== logic/camera_tx_top.sv ====
// camera byte-clock source: generator, packer, sequencer and registers
`timescale 1ns/100ps

module camera_tx_top (
    input  logic                           clock_camera_byte,
    input  logic                           reset_camera_byte_n,
    input  logic                           hs_ready_i,
    output logic                           short_packet_en_o,
    output logic                           long_packet_en_o,
    output csi_packet_pkg::csi_data_type_t data_type_o,
    output logic [15:0]                    word_count_o,
    output logic [7:0]                     byte_data_o,
    output logic                           byte_data_en_o,
    input  logic [31:0]                    awaddr_i,
    input  logic                           awvalid_i,
    output logic                           awready_o,
    input  logic [31:0]                    wdata_i,
    input  logic [3:0]                     wstrb_i,
    input  logic                           wvalid_i,
    output logic                           wready_o,
    output camera_reg_pkg::axi_resp_t      bresp_o,
    output logic                           bvalid_o,
    input  logic                           bready_i,
    input  logic [31:0]                    araddr_i,
    input  logic                           arvalid_i,
    output logic                           arready_o,
    output logic [31:0]                    rdata_o,
    output camera_reg_pkg::axi_resp_t      rresp_o,
    output logic                           rvalid_o,
    input  logic                           rready_i
);

    logic        line_start;
    logic [15:0] line_number;
    logic [9:0]  pixel_data;
    logic        pixel_valid;
    logic        pixel_ready;
    logic        enable;
    logic        frame_done;

    color_bar_generator u_color_bar_generator (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .line_start_i        (line_start),
        .line_number_i       (line_number),
        .pixel_ready_i       (pixel_ready),
        .pixel_data_o        (pixel_data),
        .pixel_valid_o       (pixel_valid)
    );

    raw10_packer u_raw10_packer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .pixel_data_i        (pixel_data),
        .pixel_valid_i       (pixel_valid),
        .pixel_ready_o       (pixel_ready),
        .byte_data_o         (byte_data_o),
        .byte_data_en_o      (byte_data_en_o)
    );

    packet_sequencer u_packet_sequencer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .enable_i            (enable),
        .hs_ready_i          (hs_ready_i),
        .byte_data_en_i      (byte_data_en_o), // payload byte count
        .line_start_o        (line_start),
        .line_number_o       (line_number),
        .short_packet_en_o   (short_packet_en_o),
        .long_packet_en_o    (long_packet_en_o),
        .data_type_o         (data_type_o),
        .word_count_o        (word_count_o),
        .frame_done_o        (frame_done)
    );

    camera_config_regs u_camera_config_regs (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .frame_done_i        (frame_done),
        .enable_o            (enable),
        .awaddr_i            (awaddr_i),
        .awvalid_i           (awvalid_i),
        .awready_o           (awready_o),
        .wdata_i             (wdata_i),
        .wstrb_i             (wstrb_i),
        .wvalid_i            (wvalid_i),
        .wready_o            (wready_o),
        .bresp_o             (bresp_o),
        .bvalid_o            (bvalid_o),
        .bready_i            (bready_i),
        .araddr_i            (araddr_i),
        .arvalid_i           (arvalid_i),
        .arready_o           (arready_o),
        .rdata_o             (rdata_o),
        .rresp_o             (rresp_o),
        .rvalid_o            (rvalid_o),
        .rready_i            (rready_i)
    );

endmodule

// ==== logic/color_bar_generator.sv ====
// color bar generator emitting one RAW10 Bayer line per line start
`timescale 1ns/100ps
`include "camera_tx_defs.svh"

module color_bar_generator (
    input  logic        clock_camera_byte,
    input  logic        reset_camera_byte_n,
    input  logic        line_start_i,
    input  logic [15:0] line_number_i,
    input  logic        pixel_ready_i,
    output logic [9:0]  pixel_data_o,
    output logic        pixel_valid_o
);

    localparam int X_BITS    = $clog2(`CAM_IMAGE_X_SIZE);
    localparam int BAR_WIDTH = `CAM_IMAGE_X_SIZE / 4;

    logic [X_BITS-1:0] x_count;
    logic              row_odd;
    logic [1:0]        bar_index;
    logic [29:0]       bar_color;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            x_count       <= '0;
            row_odd       <= 1'b0;
            pixel_valid_o <= 1'b0;
        end else if (line_start_i) begin
            x_count       <= '0;
            row_odd       <= line_number_i[0]; // only parity matters for bayer
            pixel_valid_o <= 1'b1;
        end else if (pixel_valid_o && pixel_ready_i) begin
            if (x_count == X_BITS'(`CAM_IMAGE_X_SIZE - 1)) begin
                pixel_valid_o <= 1'b0; // line complete
            end
            x_count <= x_count + 1'b1;
        end
    end

    assign bar_index = 2'(x_count / BAR_WIDTH);

    always_comb begin
        case (bar_index)
            2'd0:    bar_color = `CAM_COLOR_BAR0; // blue
            2'd1:    bar_color = `CAM_COLOR_BAR1; // yellow
            2'd2:    bar_color = `CAM_COLOR_BAR2; // pink
            default: bar_color = `CAM_COLOR_BAR3; // green
        endcase
    end

    // bayer pattern: odd rows R/G, even rows G/B
    always_comb begin
        if (row_odd) begin
            pixel_data_o = x_count[0] ? bar_color[29:20] : bar_color[19:10];
        end else begin
            pixel_data_o = x_count[0] ? bar_color[19:10] : bar_color[9:0];
        end
    end

endmodule

// ==== logic/csi_packet_pkg.sv ====
// CSI-2 data type and packet sequencer state encodings
package csi_packet_pkg;

    // data type field of the packet header
    typedef enum logic [5:0] {
        FRAME_START = 6'h00,
        FRAME_END   = 6'h01,
        RAW10       = 6'h2B
    } csi_data_type_t;

    // frame and line sequencing; WAIT states hold for hs_ready
    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_WAIT_FRAME_START,
        SEQ_FRAME_START,
        SEQ_WAIT_LINE,
        SEQ_LINE_HEADER,
        SEQ_LINE_PAYLOAD,
        SEQ_GAP,
        SEQ_WAIT_FRAME_END,
        SEQ_FRAME_END
    } sequencer_state_t;

endpackage

// ==== logic/packet_sequencer.sv ====
// packet sequencer FSM issuing frame and line packets and pacing payloads
`timescale 1ns/100ps
`include "camera_tx_defs.svh"

module packet_sequencer (
    input  logic                           clock_camera_byte,
    input  logic                           reset_camera_byte_n,
    input  logic                           enable_i,
    input  logic                           hs_ready_i,
    input  logic                           byte_data_en_i,
    output logic                           line_start_o,
    output logic [15:0]                    line_number_o,
    output logic                           short_packet_en_o,
    output logic                           long_packet_en_o,
    output csi_packet_pkg::csi_data_type_t data_type_o,
    output logic [15:0]                    word_count_o,
    output logic                           frame_done_o
);
    import csi_packet_pkg::*;

    localparam logic [15:0] WORD_COUNT = 16'(`CAM_IMAGE_X_SIZE * 10 / 8);
    localparam logic [15:0] LINE_COUNT = 16'(`CAM_IMAGE_Y_SIZE);
    localparam logic [7:0]  GAP_LAST   = 8'(`CAM_LINE_GAP - 1);

    sequencer_state_t state;
    logic [15:0]      line_count;
    logic [15:0]      frame_number;
    logic [15:0]      byte_count;
    logic [7:0]       gap_count;
    logic             frame_active;
    logic             packet_issue;
    csi_data_type_t   next_type;
    csi_data_type_t   held_type;
    logic [15:0]      next_count;
    logic [15:0]      held_count;

    // packets fire in the WAIT state once the PHY side is ready
    assign short_packet_en_o = hs_ready_i &&
        (state == SEQ_WAIT_FRAME_START || state == SEQ_WAIT_FRAME_END);
    assign long_packet_en_o  = hs_ready_i && (state == SEQ_WAIT_LINE);
    assign frame_done_o      = hs_ready_i && (state == SEQ_WAIT_FRAME_END);
    assign packet_issue      = short_packet_en_o || long_packet_en_o;
    assign line_start_o      = (state == SEQ_LINE_HEADER); // one cycle after header
    assign line_number_o     = line_count;

    always_comb begin
        next_type  = RAW10;
        next_count = WORD_COUNT;
        if (state == SEQ_WAIT_FRAME_START) begin
            next_type  = FRAME_START;
            next_count = frame_number;
        end else if (state == SEQ_WAIT_FRAME_END) begin
            next_type  = FRAME_END;
            next_count = frame_number;
        end
    end

    assign data_type_o  = packet_issue ? next_type : held_type;
    assign word_count_o = packet_issue ? next_count : held_count;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state        <= SEQ_IDLE;
            line_count   <= '0;
            frame_number <= 16'd1;
            byte_count   <= '0;
            gap_count    <= '0;
            frame_active <= 1'b0;
            held_type    <= FRAME_START;
            held_count   <= '0;
        end else begin
            if (packet_issue) begin
                held_type  <= next_type;
                held_count <= next_count;
            end
            case (state)
                SEQ_IDLE: if (enable_i) state <= SEQ_WAIT_FRAME_START;
                SEQ_WAIT_FRAME_START: if (hs_ready_i) state <= SEQ_FRAME_START;
                SEQ_FRAME_START: begin
                    frame_active <= 1'b1;
                    line_count   <= '0;
                    gap_count    <= 8'd1; // this cycle counts toward the gap
                    state        <= SEQ_GAP;
                end
                SEQ_WAIT_LINE: if (hs_ready_i) state <= SEQ_LINE_HEADER;
                SEQ_LINE_HEADER: begin
                    byte_count <= '0;
                    state      <= SEQ_LINE_PAYLOAD;
                end
                SEQ_LINE_PAYLOAD: begin
                    if (byte_data_en_i) begin
                        byte_count <= byte_count + 1'b1;
                        if (byte_count == WORD_COUNT - 1'b1) begin
                            line_count <= line_count + 1'b1;
                            gap_count  <= '0;
                            state      <= SEQ_GAP;
                        end
                    end
                end
                SEQ_GAP: begin
                    gap_count <= gap_count + 1'b1;
                    if (gap_count >= GAP_LAST) begin
                        if (!frame_active) begin
                            state <= enable_i ? SEQ_WAIT_FRAME_START : SEQ_IDLE;
                        end else if (line_count == LINE_COUNT) begin
                            state <= SEQ_WAIT_FRAME_END;
                        end else begin
                            state <= SEQ_WAIT_LINE;
                        end
                    end
                end
                SEQ_WAIT_FRAME_END: if (hs_ready_i) state <= SEQ_FRAME_END;
                SEQ_FRAME_END: begin
                    frame_number <= frame_number + 1'b1; // wraps at 16 bits
                    frame_active <= 1'b0;
                    gap_count    <= 8'd1;
                    state        <= SEQ_GAP;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/raw10_packer.sv ====
// RAW10 packer turning four pixels into five payload bytes
`timescale 1ns/100ps

module raw10_packer (
    input  logic       clock_camera_byte,
    input  logic       reset_camera_byte_n,
    input  logic [9:0] pixel_data_i,
    input  logic       pixel_valid_i,
    output logic       pixel_ready_o,
    output logic [7:0] byte_data_o,
    output logic       byte_data_en_o
);

    logic [1:0] pixel_index;
    logic       low_pending;
    logic [7:0] low_bits;
    logic       pixel_accept;

    assign pixel_ready_o = !low_pending; // hold off input during byte 4
    assign pixel_accept  = pixel_valid_i && pixel_ready_o;

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            pixel_index    <= 2'd0;
            low_pending    <= 1'b0;
            byte_data_en_o <= 1'b0;
        end else begin
            byte_data_en_o <= pixel_accept || low_pending;
            if (pixel_accept) begin
                pixel_index <= pixel_index + 1'b1;
                low_pending <= (pixel_index == 2'd3); // group of four done
            end else begin
                low_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        if (pixel_accept) begin
            byte_data_o                  <= pixel_data_i[9:2];
            low_bits[2*pixel_index +: 2] <= pixel_data_i[1:0];
        end else if (low_pending) begin
            byte_data_o <= low_bits; // pixel k low bits at 2k+1:2k
        end
    end

endmodule

// ==== testbench/camera_tx_properties.sv ====
// sequencer packet pulse and payload timing assertions and their bind
`timescale 1ns/100ps

module camera_tx_properties (
    input logic                              clock_camera_byte,
    input logic                              reset_camera_byte_n,
    input logic                              hs_ready_i,
    input logic                              short_packet_en_i,
    input logic                              long_packet_en_i,
    input logic                              byte_data_en_i,
    input csi_packet_pkg::sequencer_state_t  state_i
);
    import csi_packet_pkg::*;

    enables_exclusive: assert property (@(posedge clock_camera_byte)
        disable iff (!reset_camera_byte_n) !(short_packet_en_i && long_packet_en_i))
        else $error("short and long packet enables high in the same cycle");

    short_single_cycle: assert property (@(posedge clock_camera_byte)
        disable iff (!reset_camera_byte_n) short_packet_en_i |=> !short_packet_en_i)
        else $error("short packet enable longer than one cycle");

    long_single_cycle: assert property (@(posedge clock_camera_byte)
        disable iff (!reset_camera_byte_n) long_packet_en_i |=> !long_packet_en_i)
        else $error("long packet enable longer than one cycle");

    pulse_needs_ready: assert property (@(posedge clock_camera_byte)
        disable iff (!reset_camera_byte_n) (short_packet_en_i || long_packet_en_i) |-> hs_ready_i)
        else $error("packet issued while hs_ready was low");

    bytes_in_payload: assert property (@(posedge clock_camera_byte)
        disable iff (!reset_camera_byte_n) byte_data_en_i |-> state_i == SEQ_LINE_PAYLOAD)
        else $error("payload byte outside the line payload state");

endmodule

bind packet_sequencer camera_tx_properties u_camera_tx_properties (
    .clock_camera_byte   (clock_camera_byte),
    .reset_camera_byte_n (reset_camera_byte_n),
    .hs_ready_i          (hs_ready_i),
    .short_packet_en_i   (short_packet_en_o),
    .long_packet_en_i    (long_packet_en_o),
    .byte_data_en_i      (byte_data_en_i),
    .state_i             (state)
);

// ==== testbench/camera_tx_tb.sv ====
// clock, reset, AXI tasks, PHY monitor, reference model and checks of the camera source
`timescale 1ns/100ps
`include "camera_tx_defs.svh"

module camera_tx_tb;
    import csi_packet_pkg::*;
    import camera_reg_pkg::*;

    localparam int LINES           = `CAM_IMAGE_Y_SIZE;
    localparam int WORD_COUNT      = `CAM_IMAGE_X_SIZE * 10 / 8;
    localparam int WATCHDOG_FRAMES = 3;
    localparam int PACKET_CYCLES   = WORD_COUNT + `CAM_LINE_GAP + 20;
    localparam int WATCHDOG_NS     = WATCHDOG_FRAMES * (LINES + 2) * PACKET_CYCLES * 100;

    logic           clock_camera_byte;
    logic           reset_camera_byte_n;
    logic           hs_ready;
    logic           short_packet_en;
    logic           long_packet_en;
    csi_data_type_t data_type;
    logic [15:0]    word_count;
    logic [7:0]     byte_data;
    logic           byte_data_en;
    logic [31:0]    awaddr;
    logic           awvalid;
    logic           awready;
    logic [31:0]    wdata;
    logic [3:0]     wstrb;
    logic           wvalid;
    logic           wready;
    axi_resp_t      bresp;
    logic           bvalid;
    logic           bready;
    logic [31:0]    araddr;
    logic           arvalid;
    logic           arready;
    logic [31:0]    rdata;
    axi_resp_t      rresp;
    logic           rvalid;
    logic           rready;

    csi_data_type_t type_q[$];
    logic [15:0]    word_q[$];
    logic [7:0]     byte_q[$];
    logic [7:0]     expected_bytes[$];
    int             packet_count = 0;
    int             long_count = 0;
    int             frame_end_count = 0;
    int             error_count = 0;
    int             check_count = 0;
    int             errors_at_start = 0;
    int             tests_run = 0;
    logic           random_ready = 1'b0; // random back-pressure on hs_ready

    camera_tx_top uut (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .hs_ready_i          (hs_ready),
        .short_packet_en_o   (short_packet_en),
        .long_packet_en_o    (long_packet_en),
        .data_type_o         (data_type),
        .word_count_o        (word_count),
        .byte_data_o         (byte_data),
        .byte_data_en_o      (byte_data_en),
        .awaddr_i            (awaddr),
        .awvalid_i           (awvalid),
        .awready_o           (awready),
        .wdata_i             (wdata),
        .wstrb_i             (wstrb),
        .wvalid_i            (wvalid),
        .wready_o            (wready),
        .bresp_o             (bresp),
        .bvalid_o            (bvalid),
        .bready_i            (bready),
        .araddr_i            (araddr),
        .arvalid_i           (arvalid),
        .arready_o           (arready),
        .rdata_o             (rdata),
        .rresp_o             (rresp),
        .rvalid_o            (rvalid),
        .rready_i            (rready)
    );

    initial begin
        clock_camera_byte = 1'b0;
        forever #50 clock_camera_byte = ~clock_camera_byte;
    end

    // bayer color bar value of one pixel
    function automatic logic [9:0] pixel_at(input int x, input int y);
        logic [29:0] color;
        case (x / (`CAM_IMAGE_X_SIZE / 4))
            0:       color = `CAM_COLOR_BAR0;
            1:       color = `CAM_COLOR_BAR1;
            2:       color = `CAM_COLOR_BAR2;
            default: color = `CAM_COLOR_BAR3;
        endcase
        if (y % 2 == 1) begin
            return (x % 2 == 1) ? color[29:20] : color[19:10]; // red on odd x
        end
        return (x % 2 == 1) ? color[19:10] : color[9:0]; // blue on even x
    endfunction

    // queues the RAW10 bytes of line y
    function automatic void raw10_line(input int y);
        logic [9:0] pixel;
        logic [7:0] low_byte;
        for (int group = 0; group < `CAM_IMAGE_X_SIZE / 4; group++) begin
            for (int k = 0; k < 4; k++) begin
                pixel = pixel_at(4 * group + k, y);
                expected_bytes.push_back(pixel[9:2]);
                low_byte[2 * k +: 2] = pixel[1:0];
            end
            expected_bytes.push_back(low_byte);
        end
    endfunction

    function automatic csi_data_type_t expected_type(input int index);
        if (index == 0) return FRAME_START;
        if (index == LINES + 1) return FRAME_END;
        return RAW10;
    endfunction

    function automatic logic [15:0] expected_word(input int index, input logic [15:0] frame);
        if (index == 0 || index == LINES + 1) return frame;
        return 16'(WORD_COUNT);
    endfunction

    task automatic check_data_type(input csi_data_type_t got, input csi_data_type_t want,
                                   input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("error %0d ns: %s got %s expected %s", $time, what, got.name(), want.name());
        end
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] want, input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("error %0d ns: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("error %0d ns: payload byte got %h expected %h", $time, got, want);
        end
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t want, input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("error %0d ns: %s got %s expected %s", $time, what, got.name(), want.name());
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] want, input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("error %0d ns: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output axi_resp_t resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(posedge clock_camera_byte);
        while (!(awready && wready)) @(posedge clock_camera_byte);
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(posedge clock_camera_byte);
        while (!bvalid) @(posedge clock_camera_byte);
        resp = bresp;
        #10;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output axi_resp_t resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(posedge clock_camera_byte);
        while (!arready) @(posedge clock_camera_byte);
        #10;
        arvalid = 1'b0;
        @(posedge clock_camera_byte);
        while (!rvalid) @(posedge clock_camera_byte);
        data = rdata;
        resp = rresp;
        #10;
        rready = 1'b0;
    endtask

    task automatic wait_frame_ends(input int count);
        @(posedge clock_camera_byte);
        while (frame_end_count < count) @(posedge clock_camera_byte);
        #10;
    endtask

    task automatic wait_long_packets(input int count);
        @(posedge clock_camera_byte);
        while (long_count < count) @(posedge clock_camera_byte);
        #10;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial begin : hs_ready_driver
        void'($urandom(81));
        hs_ready = 1'b1;
        forever begin
            @(posedge clock_camera_byte);
            #10;
            hs_ready = random_ready ? (($urandom % 4) != 0) : 1'b1; // low about one cycle in four
        end
    end

    // PHY side monitor
    initial begin : phy_monitor
        forever begin
            @(posedge clock_camera_byte);
            if (short_packet_en || long_packet_en) begin
                type_q.push_back(data_type);
                word_q.push_back(word_count);
                packet_count++;
                if (long_packet_en) long_count++;
                if (short_packet_en && data_type == FRAME_END) frame_end_count++;
            end
            if (byte_data_en) byte_q.push_back(byte_data);
        end
    end

    initial begin : compare_stream
        int          packet_index;
        logic [15:0] frame_number;
        logic [7:0]  got_byte;
        packet_index = 0;
        frame_number = 16'd1;
        forever begin
            @(negedge clock_camera_byte);
            if (type_q.size() > 0) begin
                check_data_type(type_q.pop_front(), expected_type(packet_index), "data type");
                check_word(word_q.pop_front(), expected_word(packet_index, frame_number),
                           "word count");
                if (packet_index >= 1 && packet_index <= LINES) raw10_line(packet_index - 1);
                if (packet_index == LINES + 1) begin
                    packet_index = 0;
                    frame_number = frame_number + 16'd1;
                end else begin
                    packet_index++;
                end
            end
            if (byte_q.size() > 0) begin
                got_byte = byte_q.pop_front();
                if (expected_bytes.size() == 0) begin
                    error_count++;
                    $display("payload byte %h arrived outside any line packet", got_byte);
                end else begin
                    check_byte(got_byte, expected_bytes.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("run timed out before all tests finished");
        $display("Checks failed");
        $finish;
    end

    initial begin : main_sequence
        axi_resp_t   resp;
        logic [31:0] data;
        int          packets_at_stop;
        reset_camera_byte_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(posedge clock_camera_byte);
        #10;
        reset_camera_byte_n = 1'b1;
        @(posedge clock_camera_byte);
        #10;
        if (short_packet_en || long_packet_en || byte_data_en || awready || wready ||
            arready || bvalid || rvalid) begin
            error_count++;
            $display("packet or AXI outputs were not low after reset");
        end

        axi_write(`CAM_REG_CONTROL, 32'd1, resp);
        check_resp(resp, OKAY, "control write");
        axi_read(`CAM_REG_CONTROL, data, resp);
        check_resp(resp, OKAY, "control read");
        check_reg(data, 32'd1, "enable bit");
        axi_read(32'h8, data, resp);
        check_resp(resp, SLVERR, "read of unmapped address");
        axi_write(`CAM_REG_STATUS, 32'd5, resp);
        check_resp(resp, SLVERR, "write to status");
        report_test("axi access");

        wait_frame_ends(2);
        report_test("frame structure and payload");

        random_ready = 1'b1;
        wait_frame_ends(3);
        random_ready = 1'b0;
        report_test("back-pressure");

        wait_long_packets(3 * LINES + 1); // inside frame four
        axi_write(`CAM_REG_CONTROL, 32'd0, resp);
        check_resp(resp, OKAY, "control clear");
        if (frame_end_count != 3) begin
            error_count++;
            $display("enable was cleared only after frame four had already ended");
        end
        wait_frame_ends(4);
        packets_at_stop = packet_count;
        repeat (2 * PACKET_CYCLES) @(posedge clock_camera_byte);
        #10;
        if (packet_count != packets_at_stop) begin
            error_count++;
            $display("packets were still sent after the frame that was stopped");
        end
        axi_read(`CAM_REG_STATUS, data, resp);
        check_resp(resp, OKAY, "status read");
        check_reg(data, 32'(frame_end_count), "completed frames");
        if (expected_bytes.size() != 0 || type_q.size() != 0 || byte_q.size() != 0) begin
            error_count++;
            $display("some packets or payload bytes never arrived or were never checked");
        end
        report_test("stop");

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
